//--- flist.f
+incdir+verification
design/fd1094_cfg_pkg.sv
design/fd1094_bus_pkg.sv
design/fd1094_key_table.sv
design/fd1094_decrypt.sv
design/fd1094_state_ctrl.sv
design/fd1094_top.sv
verification/fd1094_tb.sv

//--- verification/fd1094_model.svh
// ####################
// reference model of the fd1094 fetch path, included inside the testbench module
// needs KEY_IDX_W and the addr_t/word_t/key_t/dstate_t aliases declared first
// model_edge runs once per rising edge, fed with the inputs of the cycle that ended
// ####################
`ifndef FD1094_MODEL_SVH
`define FD1094_MODEL_SVH

key_t                       m_keys [1 << KEY_IDX_W];
key_t                       m_gkey;
dstate_t                    m_state;
logic                       m_irq;      // interrupt mode
logic                       m_arm;      // cmp.l seen, waiting for its data word
logic                       m_staddr;   // addr bit 2 the data word must have
fd1094_bus_pkg::dec_word_t  m_dec;      // expected dut output for the current cycle

// plain word from an encrypted one
function automatic word_t cipher(input word_t enc, input key_t key, input dstate_t st);
    key_t       mix;
    logic [7:0] hi;
    logic [7:0] lo;
    mix = key ^ st;
    hi  = enc[15:8] ^ mix;
    lo  = enc[7:0] ^ ~mix;
    if (mix[0]) begin
        return {lo, hi};   // odd mix swaps the halves
    end
    return {hi, lo};
endfunction

// inverse rule, so the stimulus can ask for a given plain opcode
function automatic word_t encode(input word_t plain, input key_t key, input dstate_t st);
    key_t       mix;
    logic [7:0] hi;
    logic [7:0] lo;
    mix = key ^ st;
    if (mix[0]) begin
        lo = plain[15:8];
        hi = plain[7:0];
    end else begin
        hi = plain[15:8];
        lo = plain[7:0];
    end
    return {hi ^ mix, lo ^ ~mix};
endfunction

function automatic logic is_cmpl_word(input word_t w);
    return (w[15:12] == 4'b1011) && (w[5:0] == 6'b111100);
endfunction

function automatic dstate_t model_st();
    return m_irq ? m_gkey : m_state;
endfunction

function automatic void model_reset();
    m_gkey   = '0;
    m_state  = '0;
    m_irq    = 1'b0;
    m_arm    = 1'b0;
    m_staddr = 1'b0;
    m_dec    = '0;
endfunction

function automatic void model_edge(input fd1094_bus_pkg::fetch_t f, input logic ack,
                                   input fd1094_bus_pkg::key_wr_t kw, input logic gwe,
                                   input key_t gval);
    dstate_t st_now;
    logic    imm;
    logic    irq_next;
    st_now   = model_st();   // st seen by the fetch of the ending cycle
    irq_next = m_irq;
    imm      = m_dec.valid && m_arm && (m_dec.addr[2] == m_staddr);
    if (m_dec.valid && m_dec.word == 16'h4e73) begin
        irq_next = 1'b0;     // rte
    end
    if (ack) begin
        irq_next = 1'b1;
    end
    if (imm) begin
        m_arm = 1'b0;
        case (m_dec.word[13:12])  // the command word overrides the ack
            2'd0: m_state = {4'h0, m_dec.word[11:8]};
            2'd1: begin
                m_state  = '0;
                irq_next = 1'b0;
            end
            2'd2: irq_next = 1'b1;
            default: irq_next = 1'b0;
        endcase
    end else if (m_dec.valid && is_cmpl_word(m_dec.word)) begin
        m_arm    = 1'b1;
        m_staddr = ~m_dec.addr[2];
    end
    m_irq       = irq_next;
    m_dec.valid = f.fetch;
    if (f.fetch) begin
        m_dec.addr = f.addr;
        m_dec.word = cipher(f.enc, m_keys[f.addr[KEY_IDX_W-1:0]], st_now);
    end
    // table writes land after the read of the same edge
    if (kw.we) begin
        m_keys[kw.idx[KEY_IDX_W-1:0]] = kw.key;
    end
    if (gwe) begin
        m_gkey = gval;
    end
endfunction

`endif

//--- verification/fd1094_tb.sv
// ####################
// random and directed testbench for fd1094_top with seed 77
// outputs compared at the falling edge against the included model
// key table cut to 256 entries so every key is loaded before the first fetch
// ####################
`timescale 1ns/1ps
`default_nettype none

module fd1094_tb;

    localparam int KEY_IDX_W  = 8;
    localparam int N_KEYS     = 1 << KEY_IDX_W;
    localparam int N_RAND1    = 300;    // test 1 cycles
    localparam int N_DIRECT   = 200;    // tests 2..4 together, upper bound
    localparam int N_MIX      = 1500;   // test 5 cycles
    localparam int MAX_CYCLES = 2 * (N_KEYS + N_RAND1 + N_DIRECT + N_MIX) + 50;

    typedef fd1094_cfg_pkg::addr_t   addr_t;
    typedef fd1094_cfg_pkg::word_t   word_t;
    typedef fd1094_cfg_pkg::key_t    key_t;
    typedef fd1094_cfg_pkg::dstate_t dstate_t;

    logic                    clk;
    logic                    rst;
    addr_t                   fetch_addr;
    word_t                   fetch_enc;
    logic                    op_n;
    logic                    inta_n;
    fd1094_bus_pkg::key_wr_t key_wr;
    logic                    gkey_wr;
    key_t                    gkey_data;
    logic                    dec_valid;
    word_t                   dec_word;

    // cycle in progress that the model gets at the next edge
    fd1094_bus_pkg::fetch_t  cur_fetch;
    logic                    cur_ack;
    fd1094_bus_pkg::key_wr_t cur_kw;
    logic                    cur_gwe;
    key_t                    cur_gkey;

    int cycles      = 0;
    int checks      = 0;
    int errors      = 0;
    int test_errors = 0;
    int tests_done  = 0;

    `include "fd1094_model.svh"

    fd1094_top #(
        .KEY_IDX_W (KEY_IDX_W)
    ) u_fd1094_top (
        .clk        (clk),
        .rst        (rst),
        .fetch_addr (fetch_addr),
        .fetch_enc  (fetch_enc),
        .op_n       (op_n),
        .inta_n     (inta_n),
        .key_wr     (key_wr),
        .gkey_wr    (gkey_wr),
        .gkey_data  (gkey_data),
        .dec_valid  (dec_valid),
        .dec_word   (dec_word)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, stimulus did not complete", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic compare_outputs();
        checks++;
        assert (dec_valid === m_dec.valid) else begin
            $display("CHECK FAILED at %0t: dec_valid got %b expected %b",
                     $time, dec_valid, m_dec.valid);
            errors++;
            test_errors++;
        end
        if (m_dec.valid) begin
            checks++;
            assert (dec_word === m_dec.word) else begin
                $display("CHECK FAILED at %0t: dec_word got %h expected %h",
                         $time, dec_word, m_dec.word);
                errors++;
                test_errors++;
            end
        end
    endtask

    // model catches up at the rising edge and the next cycle defaults to idle
    task automatic cycle_start();
        @(posedge clk);
        model_edge(cur_fetch, cur_ack, cur_kw, cur_gwe, cur_gkey);
        cur_fetch = '0;
        cur_ack   = 1'b0;
        cur_kw    = '0;
        cur_gwe   = 1'b0;
    endtask

    task automatic cycle_end();
        op_n       <= ~cur_fetch.fetch;
        fetch_addr <= cur_fetch.addr;
        fetch_enc  <= cur_fetch.enc;
        inta_n     <= ~cur_ack;
        key_wr     <= cur_kw;
        gkey_wr    <= cur_gwe;
        gkey_data  <= cur_gkey;
        @(negedge clk);
        compare_outputs();   // result of the previous cycle's fetch
    endtask

    // fetch whose enc is chosen so it decrypts to plain
    task automatic fetch_plain(input addr_t a, input word_t plain, input logic ack);
        cycle_start();
        cur_fetch.fetch = 1'b1;
        cur_fetch.addr  = a;
        cur_fetch.enc   = encode(plain, m_keys[a[KEY_IDX_W-1:0]], model_st());
        cur_ack         = ack;
        cycle_end();
    endtask

    task automatic fetch_raw(input addr_t a, input word_t enc, input logic ack);
        cycle_start();
        cur_fetch.fetch = 1'b1;
        cur_fetch.addr  = a;
        cur_fetch.enc   = enc;
        cur_ack         = ack;
        cycle_end();
    endtask

    task automatic idle(input logic ack);
        cycle_start();
        cur_ack = ack;
        cycle_end();
    endtask

    task automatic load_key(input int idx, input key_t k);
        cycle_start();
        cur_kw.we  = 1'b1;
        cur_kw.idx = idx[fd1094_cfg_pkg::KEY_IDX_W-1:0];
        cur_kw.key = k;
        cycle_end();
    endtask

    task automatic load_gkey(input key_t k);
        cycle_start();
        cur_gwe  = 1'b1;
        cur_gkey = k;
        cycle_end();
    endtask

    function automatic addr_t rand_addr();
        return addr_t'($urandom());
    endfunction

    // random word that is neither cmp.l nor rte
    function automatic word_t safe_word();
        word_t w;
        w = word_t'($urandom());
        if (is_cmpl_word(w) || w == 16'h4e73) begin
            w[0] = ~w[0];
        end
        return w;
    endfunction

    function automatic word_t cmpl_word();
        logic [31:0] r;
        r = $urandom();
        return {4'b1011, r[5:0], 6'b111100};
    endfunction

    function automatic word_t data_word(input logic [1:0] code, input logic [3:0] val);
        logic [31:0] r;
        r = $urandom();
        return {r[1:0], code, val, r[15:8]};
    endfunction

    // cmp.l then its data word with an optional non-matching word between
    task automatic run_command(input logic [1:0] code, input logic [3:0] val,
                               input logic gap);
        addr_t a;
        a    = rand_addr();
        a[2] = 1'b0;
        fetch_plain(a, cmpl_word(), 1'b0);
        if (gap) begin
            fetch_plain(rand_addr() & ~23'h4, safe_word(), 1'b0);  // same half so ignored
        end
        a[2] = 1'b1;
        fetch_plain(a, data_word(code, val), 1'b0);
        repeat (6) fetch_plain(rand_addr(), safe_word(), 1'b0);
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d %s: %s, %0d errors", tests_done, name,
                 (test_errors == 0) ? "ok" : "mismatch", test_errors);
        test_errors = 0;
    endtask

    task automatic test_random_mix();
        int          pick;
        logic [31:0] r;
        logic        ack;
        for (int i = 0; i < N_MIX; i++) begin
            pick = $urandom_range(0, 99);
            r    = $urandom();
            ack  = (r[31:25] < 7'd4);   // about 3 percent
            if (pick < 10) begin
                fetch_plain(rand_addr(), cmpl_word(), ack);
            end else if (pick < 20) begin
                fetch_plain(rand_addr(), data_word(r[1:0], r[7:4]), ack);
            end else if (pick < 23) begin
                fetch_plain(rand_addr(), 16'h4e73, ack);
            end else if (pick < 24) begin
                load_gkey(r[15:8]);
            end else if (pick < 88) begin
                fetch_raw(rand_addr(), r[23:8], ack);
            end else begin
                idle(ack);
            end
        end
    endtask

    initial begin
        void'($urandom(77));
        rst        = 1'b1;
        op_n       = 1'b1;
        inta_n     = 1'b1;
        fetch_addr = '0;
        fetch_enc  = '0;
        key_wr     = '0;
        gkey_wr    = 1'b0;
        gkey_data  = '0;
        cur_fetch  = '0;
        cur_ack    = 1'b0;
        cur_kw     = '0;
        cur_gwe    = 1'b0;
        cur_gkey   = '0;
        model_reset();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // test 1 loads all keys then runs a plain stream at state 0
        for (int i = 0; i < N_KEYS; i++) begin
            load_key(i, key_t'($urandom()));
        end
        for (int i = 0; i < N_RAND1; i++) begin
            if ($urandom_range(0, 3) != 0) begin
                fetch_plain(rand_addr(), safe_word(), 1'b0);
            end else begin
                idle(1'b0);
            end
        end
        idle(1'b0);
        finish_test("decrypt at state 0");

        // state load with and without a word between
        run_command(2'd0, 4'($urandom_range(1, 15)), 1'b0);
        run_command(2'd0, 4'($urandom_range(1, 15)), 1'b1);
        finish_test("state load");

        // inta pulse with gkey forced away from the stored state
        load_gkey(m_state ^ key_t'($urandom_range(1, 255)));
        idle(1'b1);
        repeat (6) fetch_plain(rand_addr(), safe_word(), 1'b0);
        fetch_plain(rand_addr(), 16'h4e73, 1'b0);
        repeat (6) fetch_plain(rand_addr(), safe_word(), 1'b0);
        fetch_plain(rand_addr(), safe_word(), 1'b1);   // ack during a fetch
        repeat (4) fetch_plain(rand_addr(), safe_word(), 1'b0);
        fetch_plain(rand_addr(), 16'h4e73, 1'b0);
        repeat (4) fetch_plain(rand_addr(), safe_word(), 1'b0);
        finish_test("interrupt mode by inta_n");

        // gkey apart from 0, 0xc and the 1..15 loaded state
        load_gkey(8'ha5);
        run_command(2'd2, 4'h0, 1'b0);
        run_command(2'd3, 4'h0, 1'b1);
        run_command(2'd0, 4'hc, 1'b0);
        run_command(2'd2, 4'h0, 1'b0);
        run_command(2'd1, 4'h0, 1'b0);
        finish_test("commands 1 2 3");

        // back to back mix
        test_random_mix();
        idle(1'b0);
        finish_test("random mix");

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/fd1094_top.sv
// ####################
// encrypted opcode fetch path, key table + decrypt + state control
// op_n low for one cycle per opcode fetch, dec_word one clock later
// no back-pressure, a fetch may come every cycle
// ####################
`timescale 1ns/1ps
`default_nettype none

module fd1094_top #(
    parameter int KEY_IDX_W = 12    // key table depth, log2
) (
    input  wire                         clk,
    input  wire                         rst,
    input  fd1094_cfg_pkg::addr_t       fetch_addr,
    input  fd1094_cfg_pkg::word_t       fetch_enc,
    input  wire                         op_n,        // opcode fetch strobe
    input  wire                         inta_n,      // interrupt ack
    input  fd1094_bus_pkg::key_wr_t     key_wr,
    input  wire                         gkey_wr,
    input  fd1094_cfg_pkg::key_t        gkey_data,
    output logic                        dec_valid,
    output fd1094_cfg_pkg::word_t       dec_word
);

    fd1094_bus_pkg::fetch_t     fetch;
    fd1094_bus_pkg::dec_word_t  dec;
    fd1094_cfg_pkg::key_t       key;        // per-address key byte
    fd1094_cfg_pkg::key_t       gkey;
    fd1094_cfg_pkg::dstate_t    st;         // current decryption state

    // fetch context, strobe turned active high
    assign fetch.addr  = fetch_addr;
    assign fetch.enc   = fetch_enc;
    assign fetch.fetch = ~op_n;

    fd1094_key_table #(
        .KEY_IDX_W (KEY_IDX_W)
    ) u_key_table (
        .clk       (clk),
        .rst       (rst),
        .key_wr    (key_wr),
        .gkey_wr   (gkey_wr),
        .gkey_data (gkey_data),
        .rd_idx    (fetch_addr[KEY_IDX_W-1:0]),  // low word address bits
        .key       (key),
        .gkey      (gkey)
    );

    fd1094_decrypt u_decrypt (
        .clk   (clk),
        .rst   (rst),
        .fetch (fetch),
        .key   (key),
        .st    (st),
        .dec   (dec)
    );

    // watches the decrypted stream, feeds st back to decrypt
    fd1094_state_ctrl u_state_ctrl (
        .clk    (clk),
        .rst    (rst),
        .dec    (dec),
        .inta_n (inta_n),
        .gkey   (gkey),
        .st     (st)
    );

    assign dec_valid = dec.valid;
    assign dec_word  = dec.word;

endmodule

`default_nettype wire

//--- design/fd1094_state_ctrl.sv
// ####################
// decryption state and irq mode, driven by the decrypted opcode stream
// a cmp.l #imm arms a change, its data word (matched on addr bit 2) runs it
// st is the global key while in irq mode
// ####################
`timescale 1ns/1ps
`default_nettype none

module fd1094_state_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  fd1094_bus_pkg::dec_word_t   dec,
    input  wire                         inta_n,
    input  fd1094_cfg_pkg::key_t        gkey,
    output fd1094_cfg_pkg::dstate_t     st
);

    // waiting for the immediate data word or not
    typedef enum logic {
        ARM_IDLE,
        ARM_WAIT
    } arm_t;

    arm_t                     arm_q;
    logic                     staddr_q;   // expected addr bit 2 of the data word
    fd1094_cfg_pkg::dstate_t  state_q;
    logic                     irq_q;      // irq mode
    logic                     is_cmpl;
    logic                     is_rte;
    logic                     is_imm;     // this word is the armed data word
    fd1094_cfg_pkg::cmd_t     cmd;

    // decode of the current decrypted word
    assign is_cmpl = dec.valid
                   && dec.word[15:12] == fd1094_cfg_pkg::CMPL_HI
                   && dec.word[5:0] == fd1094_cfg_pkg::CMPL_EA;
    assign is_rte  = dec.valid && dec.word == fd1094_cfg_pkg::OP_RTE;
    assign is_imm  = dec.valid && arm_q == ARM_WAIT && dec.addr[2] == staddr_q;
    assign cmd     = dec.word[13:12];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arm_q    <= ARM_IDLE;
            staddr_q <= 1'b0;
            state_q  <= '0;
            irq_q    <= 1'b0;
        end else begin
            if (is_rte) irq_q <= 1'b0;   // rte leaves irq mode
            if (!inta_n) irq_q <= 1'b1;  // ack beats rte

            if (is_imm) begin
                arm_q <= ARM_IDLE;       // one command per cmp.l
                // command word has the last say over irq mode
                case (cmd)
                    fd1094_cfg_pkg::CMD_LOAD:  state_q <= {4'b0000, dec.word[11:8]};
                    fd1094_cfg_pkg::CMD_CLR: begin
                        state_q <= '0;
                        irq_q   <= 1'b0;
                    end
                    fd1094_cfg_pkg::CMD_IRQ:   irq_q <= 1'b1;
                    fd1094_cfg_pkg::CMD_NOIRQ: irq_q <= 1'b0;
                endcase
            end else if (is_cmpl) begin
                arm_q    <= ARM_WAIT;
                staddr_q <= ~dec.addr[2];  // data word sits in the other half
            end
        end
    end

    // key material for the next fetch
    assign st = irq_q ? gkey : state_q;

endmodule

`default_nettype wire

//--- design/fd1094_decrypt.sv
// ####################
// keyed opcode word decryption, one register stage
// the mixing rule is a stand-in, not the real fd1094 cipher
// st must be the value of the strobe cycle; result shows one clock later
// ####################
`timescale 1ns/1ps
`default_nettype none

module fd1094_decrypt (
    input  wire                         clk,
    input  wire                         rst,
    input  fd1094_bus_pkg::fetch_t      fetch,
    input  fd1094_cfg_pkg::key_t        key,
    input  fd1094_cfg_pkg::dstate_t     st,
    output fd1094_bus_pkg::dec_word_t   dec
);

    fd1094_cfg_pkg::key_t   mix;        // per-fetch mixing byte
    logic [7:0]             hi_x;       // high byte after xor
    logic [7:0]             lo_x;       // low byte after xor with ~mix
    fd1094_cfg_pkg::word_t  plain;
    logic                   valid_q;
    fd1094_cfg_pkg::addr_t  addr_q;
    fd1094_cfg_pkg::word_t  word_q;

    // mixing rule
    //   mix   = key ^ st
    //   word  = {enc_hi ^ mix, enc_lo ^ ~mix}
    //   bytes swapped when mix[0] is set
    always_comb begin
        mix  = key ^ st;
        hi_x = fetch.enc[15:8] ^ mix;
        lo_x = fetch.enc[7:0] ^ ~mix;
        if (mix[0]) begin
            plain = {lo_x, hi_x};   // swapped
        end else begin
            plain = {hi_x, lo_x};
        end
    end

    // valid follows the strobe by one clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch.fetch;
        end
    end

    // payload, captured on every strobe
    always_ff @(posedge clk) begin
        if (fetch.fetch) begin
            addr_q <= fetch.addr;
            word_q <= plain;
        end
    end

    assign dec.valid = valid_q;
    assign dec.addr  = addr_q;
    assign dec.word  = word_q;

endmodule

`default_nettype wire

//--- design/fd1094_key_table.sv
// ####################
// key byte memory, one byte per low-address slot, plus the global key
// KEY_IDX_W must not exceed fd1094_cfg_pkg::KEY_IDX_W (write index width)
// read is combinational, memory contents are undefined after power-up
// ####################
`timescale 1ns/1ps
`default_nettype none

module fd1094_key_table #(
    parameter int KEY_IDX_W = 12
) (
    input  wire                           clk,
    input  wire                           rst,
    input  fd1094_bus_pkg::key_wr_t       key_wr,
    input  wire                           gkey_wr,
    input  fd1094_cfg_pkg::key_t          gkey_data,
    input  wire [KEY_IDX_W-1:0]           rd_idx,
    output fd1094_cfg_pkg::key_t          key,
    output fd1094_cfg_pkg::key_t          gkey
);

    localparam int DEPTH = 1 << KEY_IDX_W;

    fd1094_cfg_pkg::key_t  mem [DEPTH];    // key bytes
    fd1094_cfg_pkg::key_t  gkey_q;         // global key, used in irq mode
    logic [KEY_IDX_W-1:0]  wr_idx;

    // table may be shallower than the write port's index field
    assign wr_idx = key_wr.idx[KEY_IDX_W-1:0];

    // write port, no reset on the array
    always_ff @(posedge clk) begin
        if (key_wr.we) begin
            mem[wr_idx] <= key_wr.key;
        end
    end

    // global key register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gkey_q <= '0;
        end else if (gkey_wr) begin
            gkey_q <= gkey_data;  // load from outside
        end
    end

    // async read, same cycle as the fetch strobe
    assign key  = mem[rd_idx];
    assign gkey = gkey_q;

endmodule

`default_nettype wire

//--- design/fd1094_bus_pkg.sv
// ####################
// traffic structs between the fetch inputs, key table, decrypt and state control
// field widths come from fd1094_cfg_pkg
// ####################
`default_nettype none

package fd1094_bus_pkg;

    // opcode fetch context as seen on the cpu side, 40 bits
    typedef struct packed {
        fd1094_cfg_pkg::addr_t addr;   // word address
        fd1094_cfg_pkg::word_t enc;    // encrypted opcode word
        logic                  fetch;  // opcode fetch strobe, active high here
    } fetch_t;

    // key table write port
    typedef struct packed {
        logic                                 we;
        logic [fd1094_cfg_pkg::KEY_IDX_W-1:0] idx;
        fd1094_cfg_pkg::key_t                 key;
    } key_wr_t;

    // decrypted word leaving the decrypt stage, 40 bits
    // valid for exactly one cycle per fetch
    typedef struct packed {
        logic                  valid;
        fd1094_cfg_pkg::addr_t addr;   // address of the fetch it came from
        fd1094_cfg_pkg::word_t word;   // plain opcode or data word
    } dec_word_t;

endpackage

`default_nettype wire

//--- design/fd1094_cfg_pkg.sv
// ####################
// cipher widths and opcode constants for the fd1094 fetch path
// key index width here sets the key_wr_t index field; the table may use fewer bits
// ####################
`default_nettype none

package fd1094_cfg_pkg;

    // widths that carry a meaning
    localparam int ADDR_W    = 23;  // word address, a[23:1]
    localparam int WORD_W    = 16;
    localparam int KEY_W     = 8;
    localparam int KEY_IDX_W = 12;  // default key table depth, 4k bytes

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [KEY_W-1:0]  key_t;
    typedef logic [KEY_W-1:0]  dstate_t;   // decryption state
    typedef logic [1:0]        cmd_t;      // command code from imm word bits 13..12

    // return from exception
    localparam word_t OP_RTE = 16'h4e73;

    // cmp.l #imm,<ea> match: top nibble and low six ea bits
    localparam logic [3:0] CMPL_HI = 4'b1011;
    localparam logic [5:0] CMPL_EA = 6'b111100;

    // command codes carried by the immediate data word
    localparam cmd_t CMD_LOAD  = 2'd0;  // state <= imm[11:8]
    localparam cmd_t CMD_CLR   = 2'd1;  // state cleared, irq mode off
    localparam cmd_t CMD_IRQ   = 2'd2;  // enter irq mode
    localparam cmd_t CMD_NOIRQ = 2'd3;  // leave irq mode

endpackage

`default_nettype wire
